// File: Bender.yml
package:
  name: codec

dependencies: {}

sources:
  - files:
      - src/codec_pkg.sv
      - src/frame_slicer.sv
      - src/conv_encoder.sv
      - src/viterbi_decoder.sv
      - src/codec_top.sv
  - target: simulation
    files:
      - sim/codec_properties.sv
      - sim/codec_tb.sv

// File: compile.f
src/codec_pkg.sv
src/frame_slicer.sv
src/conv_encoder.sv
src/viterbi_decoder.sv
src/codec_top.sv
sim/codec_properties.sv
sim/codec_tb.sv

// File: sim/codec_properties.sv
`timescale 1ns/1ps

module codec_properties import codec_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                i_start,
    input  logic                i_mode_sel,
    input  logic                i_tx_valid,
    input  logic                i_dec_done,
    input  logic                i_busy,
    input  logic [MSG_BITS-1:0] i_dec_frame
);

    logic started;   // a start was seen since reset
    int   assert_fails = 0;

    always_ff @(posedge clk)
    begin
        if (!rst)
            started <= 1'b0;
        else if (i_start)
            started <= 1'b1;
    end

    done_single: assert property (@(posedge clk) disable iff (!rst)
        i_dec_done |=> !i_dec_done)
        else
        begin
            assert_fails++;
            $error("o_dec_done held for more than one cycle");
        end

    no_tx_in_decode: assert property (@(posedge clk) disable iff (!rst)
        (i_mode_sel == DECODE_MODE) |-> !i_tx_valid)
        else
        begin
            assert_fails++;
            $error("o_tx_valid high in decode mode");
        end

    quiet_until_start: assert property (@(posedge clk) disable iff (!rst)
        !started |-> (!i_tx_valid && !i_dec_done && !i_busy && i_dec_frame == '0))
        else
        begin
            assert_fails++;
            $error("outputs active after reset before any start");
        end

endmodule

bind codec_top codec_properties u_props (
    .clk         (clk),
    .rst         (rst),
    .i_start     (i_start),
    .i_mode_sel  (i_mode_sel),
    .i_tx_valid  (o_tx_valid),
    .i_dec_done  (o_dec_done),
    .i_busy      (o_busy),
    .i_dec_frame (o_dec_frame)
);

// File: sim/codec_tb.sv
`timescale 1ns/1ps

module codec_tb
    import codec_pkg::*;
();

    localparam int TOTAL_STEPS     = 2 * MSG_BITS + 6 * STEPS_DEC;   // all frames of the run
    localparam int WATCHDOG_CYCLES = TOTAL_STEPS * 300;

    logic                     clk;
    logic                     rst;
    logic                     i_start;
    logic                     i_en;
    logic                     i_mode_sel;
    logic                     i_code_rate;
    logic [MSG_BITS-1:0]      i_msg_frame;
    logic [CODE_BITS_MAX-1:0] i_code_frame;
    logic [2:0]               o_tx_sym;
    logic                     o_tx_valid;
    logic [MSG_BITS-1:0]      o_dec_frame;
    logic                     o_dec_done;
    logic                     o_busy;

    logic [31:0]              lfsr_state = 32'hf8a3fb59;
    logic [2:0]               exp_sym [MSG_BITS];
    logic [CODE_BITS_MAX-1:0] exp_code;
    int                       value_errors = 0;
    int                       event_errors = 0;

    codec_top i_dut (
        .clk          (clk),
        .rst          (rst),
        .i_start      (i_start),
        .i_en         (i_en),
        .i_mode_sel   (i_mode_sel),
        .i_code_rate  (i_code_rate),
        .i_msg_frame  (i_msg_frame),
        .i_code_frame (i_code_frame),
        .o_tx_sym     (o_tx_sym),
        .o_tx_valid   (o_tx_valid),
        .o_dec_frame  (o_dec_frame),
        .o_dec_done   (o_dec_done),
        .o_busy       (o_busy)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    function automatic logic take_bit();
        lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
        return lfsr_state[0];
    endfunction

    task automatic random_frame(output logic [MSG_BITS-1:0] frame);
        for (int i = 0; i < MSG_BITS; i++)
            frame[i] = take_bit();
    endtask

    // bit position of generator k of symbol j in the received frame
    function automatic int code_pos(input int j, input int k, input logic rate);
        if (rate == CODE_RATE_3)
            return CODE_BITS_MAX - 1 - 3 * j - k;
        return 2 * MSG_BITS - 1 - 2 * j - k;
    endfunction

    task automatic encode_model(input logic [MSG_BITS-1:0] msg, input logic rate);
        logic       newest;
        logic       prev1;
        logic       prev2;
        logic [2:0] taps;
        logic [2:0] sym;
        prev1    = 1'b0;
        prev2    = 1'b0;
        exp_code = '0;
        for (int j = 0; j < MSG_BITS; j++)
        begin
            newest = msg[MSG_BITS - 1 - j];   // msb goes first
            taps   = {newest, prev1, prev2};
            sym[0] = ^(taps & GEN_0);
            sym[1] = ^(taps & GEN_1);
            sym[2] = (rate == CODE_RATE_3) ? ^(taps & GEN_2) : 1'b0;
            exp_sym[j] = sym;
            for (int k = 0; k < ((rate == CODE_RATE_3) ? 3 : 2); k++)
                exp_code[code_pos(j, k, rate)] = sym[k];
            prev2 = prev1;
            prev1 = newest;
        end
    endtask

    task automatic check_sym(input string name, input logic [2:0] got, input logic [2:0] exp);
        if (got !== exp)
        begin
            value_errors++;
            $display("[FAIL] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_frame(input string name, input logic [MSG_BITS-1:0] got,
                               input logic [MSG_BITS-1:0] exp);
        if (got !== exp)
        begin
            value_errors++;
            $display("[FAIL] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic start_frame(input logic mode, input logic rate);
        @(negedge clk);
        i_mode_sel  = mode;
        i_code_rate = rate;
        i_start     = 1'b1;
        i_en        = 1'b0;
        @(negedge clk);
        i_start = 1'b0;
    endtask

    task automatic run_encode(input logic rate, input logic gate_en);
        logic [MSG_BITS-1:0] msg;
        logic [1:0]          exp_pipe;   // enabled steps, two cycles to o_tx_valid
        logic                en_nxt;
        int                  issued;
        int                  received;
        int                  cycles;
        random_frame(msg);
        encode_model(msg, rate);
        i_msg_frame = msg;
        start_frame(ENCODE_MODE, rate);
        exp_pipe = 2'b00;
        issued   = 0;
        received = 0;
        cycles   = 0;
        while ((issued < MSG_BITS || exp_pipe != 2'b00) && cycles < 8 * MSG_BITS)
        begin
            if (o_tx_valid !== exp_pipe[1])
            begin
                event_errors++;
                if (exp_pipe[1])
                    $display("tx strobe missing for symbol %0d", received);
                else
                    $display("tx strobe without an enabled step");
            end
            if (o_tx_valid === 1'b1)
            begin
                if (received < MSG_BITS)
                    check_sym("o_tx_sym", o_tx_sym, exp_sym[received]);
                received++;
            end
            en_nxt   = gate_en ? take_bit() : 1'b1;
            exp_pipe = {exp_pipe[0], en_nxt && (issued < MSG_BITS)};
            if (en_nxt && issued < MSG_BITS)
                issued++;
            i_en = en_nxt;
            @(negedge clk);
            cycles++;
        end
        repeat (4)
        begin
            if (o_tx_valid !== 1'b0)
            begin
                event_errors++;
                $display("tx strobe after the frame ended");
            end
            @(negedge clk);
        end
        i_en = 1'b0;
        if (received != MSG_BITS)
        begin
            event_errors++;
            $display("encode frame gave %0d symbols instead of %0d", received, MSG_BITS);
        end
    endtask

    task automatic run_decode(input logic rate, input logic [MSG_BITS-1:0] msg,
                              input logic add_errors);
        int                       flip_sym [4] = '{12, 37, 61, 90};   // 20+ symbols apart
        logic [CODE_BITS_MAX-1:0] code;
        int                       pos;
        int                       cycles;
        logic                     busy_seen;
        encode_model(msg, rate);
        code = exp_code;
        if (add_errors)
        begin
            for (int e = 0; e < 4; e++)
            begin
                pos       = code_pos(flip_sym[e], e % ((rate == CODE_RATE_3) ? 3 : 2), rate);
                code[pos] = ~code[pos];
            end
        end
        i_code_frame = code;
        start_frame(DECODE_MODE, rate);
        i_en      = 1'b1;
        cycles    = 0;
        busy_seen = 1'b0;
        while (o_dec_done !== 1'b1 && cycles < 4 * STEPS_DEC)
        begin
            if (o_busy === 1'b1)
                busy_seen = 1'b1;
            @(negedge clk);
            cycles++;
        end
        i_en = 1'b0;
        if (o_dec_done !== 1'b1)
        begin
            event_errors++;
            $display("decoder never raised o_dec_done");
        end
        else
        begin
            check_frame("o_dec_frame", o_dec_frame, msg);
            if (!busy_seen)
            begin
                event_errors++;
                $display("o_busy never went high while the frame was decoded");
            end
            if (o_busy !== 1'b0)
            begin
                event_errors++;
                $display("o_busy still high at o_dec_done");
            end
        end
    endtask

    task automatic test_encode_rate2();
        run_encode(CODE_RATE_2, 1'b0);
    endtask

    task automatic test_encode_rate3_gated();
        run_encode(CODE_RATE_3, 1'b1);
    endtask

    task automatic test_decode_clean();
        logic [MSG_BITS-1:0] msg;
        random_frame(msg);
        run_decode(CODE_RATE_2, msg, 1'b0);
        random_frame(msg);
        run_decode(CODE_RATE_3, msg, 1'b0);
    endtask

    task automatic test_decode_errors();
        logic [MSG_BITS-1:0] msg;
        random_frame(msg);
        run_decode(CODE_RATE_2, msg, 1'b1);
        random_frame(msg);
        run_decode(CODE_RATE_3, msg, 1'b1);
    endtask

    task automatic test_back_to_back();
        logic [MSG_BITS-1:0] msg;
        random_frame(msg);
        run_decode(CODE_RATE_3, msg, 1'b1);
        random_frame(msg);
        run_decode(CODE_RATE_2, msg, 1'b0);   // starts right after the done pulse
    endtask

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("run stopped by the watchdog, tests did not finish in time");
        $display("STATUS: FAIL");
        $finish;
    end

    initial
    begin
        rst          = 1'b0;
        i_start      = 1'b0;
        i_en         = 1'b0;
        i_mode_sel   = ENCODE_MODE;
        i_code_rate  = CODE_RATE_2;
        i_msg_frame  = '0;
        i_code_frame = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        repeat (2) @(negedge clk);
        test_encode_rate2();
        test_encode_rate3_gated();
        test_decode_clean();
        test_decode_errors();
        test_back_to_back();
        repeat (4) @(negedge clk);
        $display("summary: %0d value mismatches, %0d strobe or timing errors, %0d assertion failures",
                 value_errors, event_errors, i_dut.u_props.assert_fails);
        if (value_errors == 0 && event_errors == 0 && i_dut.u_props.assert_fails == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

// File: src/codec_pkg.sv
package codec_pkg;

    localparam int MSG_BITS      = 128;   // message frame length
    localparam int CODE_BITS_MAX = 384;   // widest received frame, rate 1/3
    localparam int STEPS_DEC     = 64;    // two trellis steps per word
    localparam int NUM_STATES    = 4;     // constraint length 3
    localparam int METRIC_W      = 8;

    localparam logic ENCODE_MODE = 1'b0;
    localparam logic DECODE_MODE = 1'b1;

    localparam logic CODE_RATE_2 = 1'b0;
    localparam logic CODE_RATE_3 = 1'b1;

    // tap 2 is the newest input bit
    localparam logic [2:0] GEN_0 = 3'o7;
    localparam logic [2:0] GEN_1 = 3'o5;
    localparam logic [2:0] GEN_2 = 3'o3;

    // two code symbols per decode step, bit k of a symbol is generator k
    typedef union packed {
        struct packed {
            logic       pad1;
            logic [1:0] sym1;
            logic       pad0;
            logic [1:0] sym0;
        } r2;
        struct packed {
            logic [2:0] sym1;
            logic [2:0] sym0;
        } r3;
    } slice_word_u;

endpackage

// File: src/codec_top.sv
`timescale 1ns/1ps

module codec_top import codec_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     i_start,
    input  logic                     i_en,
    input  logic                     i_mode_sel,
    input  logic                     i_code_rate,
    input  logic [MSG_BITS-1:0]      i_msg_frame,
    input  logic [CODE_BITS_MAX-1:0] i_code_frame,
    output logic [2:0]               o_tx_sym,
    output logic                     o_tx_valid,
    output logic [MSG_BITS-1:0]      o_dec_frame,
    output logic                     o_dec_done,
    output logic                     o_busy
);

    logic        slice_bit;
    logic        slice_bit_valid;
    slice_word_u slice_word;
    logic        slice_word_valid;
    logic        slice_first;

    frame_slicer u_slicer (
        .clk          (clk),
        .rst          (rst),
        .i_start      (i_start),
        .i_en         (i_en),
        .i_mode_sel   (i_mode_sel),
        .i_code_rate  (i_code_rate),
        .i_msg_frame  (i_msg_frame),
        .i_code_frame (i_code_frame),
        .o_bit        (slice_bit),
        .o_bit_valid  (slice_bit_valid),
        .o_word       (slice_word),
        .o_word_valid (slice_word_valid),
        .o_first      (slice_first)
    );

    conv_encoder u_encoder (
        .clk         (clk),
        .rst         (rst),
        .i_start     (i_start),
        .i_code_rate (i_code_rate),
        .i_bit       (slice_bit),
        .i_bit_valid (slice_bit_valid),
        .o_sym       (o_tx_sym),
        .o_sym_valid (o_tx_valid)
    );

    viterbi_decoder u_decoder (
        .clk          (clk),
        .rst          (rst),
        .i_code_rate  (i_code_rate),
        .i_word       (slice_word),
        .i_word_valid (slice_word_valid),
        .i_first      (slice_first),
        .o_frame      (o_dec_frame),
        .o_done       (o_dec_done),
        .o_busy       (o_busy)
    );

endmodule

// File: src/conv_encoder.sv
`timescale 1ns/1ps

module conv_encoder import codec_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       i_start,
    input  logic       i_code_rate,
    input  logic       i_bit,
    input  logic       i_bit_valid,
    output logic [2:0] o_sym,
    output logic       o_sym_valid
);

    logic [1:0] sr;      // sr[1] is the previous bit
    logic [2:0] win;
    logic [2:0] sym_nxt;

    assign win = {i_bit, sr};

    always_comb
    begin
        sym_nxt[0] = ^(win & GEN_0);
        sym_nxt[1] = ^(win & GEN_1);
        sym_nxt[2] = (i_code_rate == CODE_RATE_3) ? ^(win & GEN_2) : 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            sr          <= 2'b00;
            o_sym_valid <= 1'b0;
        end
        else
        begin
            o_sym_valid <= i_bit_valid;
            if (i_start)
                sr <= 2'b00;   // every frame starts in state 0
            else if (i_bit_valid)
                sr <= {i_bit, sr[1]};
        end
    end

    always_ff @(posedge clk)
    begin
        if (i_bit_valid)
            o_sym <= sym_nxt;
    end

endmodule

// File: src/frame_slicer.sv
`timescale 1ns/1ps

module frame_slicer import codec_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     i_start,
    input  logic                     i_en,
    input  logic                     i_mode_sel,
    input  logic                     i_code_rate,
    input  logic [MSG_BITS-1:0]      i_msg_frame,
    input  logic [CODE_BITS_MAX-1:0] i_code_frame,
    output logic                     o_bit,
    output logic                     o_bit_valid,
    output slice_word_u              o_word,
    output logic                     o_word_valid,
    output logic                     o_first
);

    logic [6:0]                 msg_cnt;
    logic [8:0]                 code_cnt;
    logic [8:0]                 code_top;
    logic [8:0]                 code_step;
    logic                       run;
    logic                       step;
    logic                       last_step;
    logic [CODE_BITS_MAX+1:0]   code_pad;
    logic [5:0]                 grp;
    slice_word_u                word_nxt;

    assign code_top  = (i_code_rate == CODE_RATE_3) ? 9'(CODE_BITS_MAX - 1) : 9'(2 * MSG_BITS - 1);
    assign code_step = (i_code_rate == CODE_RATE_3) ? 9'd6 : 9'd4;
    assign step      = run && i_en;

    assign last_step = (i_mode_sel == ENCODE_MODE) ? (msg_cnt == 7'd0)
                                                   : (code_cnt == code_step - 9'd1);

    // two zero bits below the frame keep the 6-bit window in range at rate 1/2
    assign code_pad = {i_code_frame, 2'b00};
    assign grp      = code_pad[code_cnt + 9'd2 -: 6];   // grp[5] is frame[code_cnt]

    always_comb
    begin
        word_nxt = '0;
        if (i_code_rate == CODE_RATE_3)
        begin
            word_nxt.r3.sym0 = {grp[3], grp[4], grp[5]};
            word_nxt.r3.sym1 = {grp[0], grp[1], grp[2]};
        end
        else
        begin
            word_nxt.r2.sym0 = {grp[4], grp[5]};
            word_nxt.r2.sym1 = {grp[2], grp[3]};
        end
    end

    always_ff @(posedge clk) // frame counters
    begin
        if (!rst || i_start)
        begin
            msg_cnt  <= 7'(MSG_BITS - 1);
            code_cnt <= code_top;
        end
        else if (step)
        begin
            if (i_mode_sel == ENCODE_MODE)
                msg_cnt <= msg_cnt - 7'd1;
            else
                code_cnt <= code_cnt - code_step;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            run          <= 1'b0;
            o_bit_valid  <= 1'b0;
            o_word_valid <= 1'b0;
            o_first      <= 1'b0;
        end
        else if (i_start)
        begin
            run          <= 1'b1;
            o_bit_valid  <= 1'b0;
            o_word_valid <= 1'b0;
            o_first      <= 1'b0;
        end
        else
        begin
            o_bit_valid  <= step && (i_mode_sel == ENCODE_MODE);
            o_word_valid <= step && (i_mode_sel == DECODE_MODE);
            o_first      <= step && (i_mode_sel == DECODE_MODE) && (code_cnt == code_top);
            if (step && last_step)
                run <= 1'b0;   // frame complete
        end
    end

    always_ff @(posedge clk) // payload, qualified by the strobes
    begin
        if (step)
        begin
            o_bit  <= i_msg_frame[msg_cnt];
            o_word <= word_nxt;
        end
    end

endmodule

// File: src/viterbi_decoder.sv
`timescale 1ns/1ps

module viterbi_decoder import codec_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                i_code_rate,
    input  slice_word_u         i_word,
    input  logic                i_word_valid,
    input  logic                i_first,
    output logic [MSG_BITS-1:0] o_frame,
    output logic                o_done,
    output logic                o_busy
);

    logic [NUM_STATES-1:0][METRIC_W-1:0] pm;
    logic [NUM_STATES-1:0][METRIC_W-1:0] pm_init;
    logic [NUM_STATES-1:0][METRIC_W-1:0] pm_src;
    logic [NUM_STATES-1:0][METRIC_W-1:0] pm_mid;
    logic [NUM_STATES-1:0][METRIC_W-1:0] pm_new;
    logic [NUM_STATES-1:0]               dec_a;
    logic [NUM_STATES-1:0]               dec_b;
    logic [2*NUM_STATES-1:0]             surv [STEPS_DEC];
    logic [2*NUM_STATES-1:0]             surv_rd;
    logic [2:0]                          rx_a;
    logic [2:0]                          rx_b;
    logic                                rate3;
    logic [5:0]                          wr_idx;
    logic [5:0]                          cur_idx;
    logic                                last_word;
    logic                                collecting;
    logic                                trace_pend;
    logic                                tracing;
    logic [1:0]                          best;
    logic [1:0]                          tb_state;
    logic [1:0]                          mid_state;
    logic [5:0]                          tb_idx;
    logic                                d_a;
    logic                                d_b;
    logic [MSG_BITS-1:0]                 tb_bits;
    logic [MSG_BITS-1:0]                 tb_shift;

    // hamming distance to the expected symbol of one transition
    function automatic logic [1:0] branch_metric(
        input logic [2:0] rx,
        input logic [2:0] win,
        input logic       r3
    );
        logic [2:0] exp_sym;
        logic [2:0] diff;
        exp_sym = {^(win & GEN_2), ^(win & GEN_1), ^(win & GEN_0)};
        diff    = (rx ^ exp_sym) & {r3, 2'b11};   // bit 2 unused at rate 1/2
        return {1'b0, diff[0]} + {1'b0, diff[1]} + {1'b0, diff[2]};
    endfunction

    // next state n = {b, p1}, predecessors {n[0], 0} and {n[0], 1}
    function automatic void acs_step(
        input  logic [NUM_STATES-1:0][METRIC_W-1:0] pm_in,
        input  logic [2:0]                          rx,
        input  logic                                r3,
        output logic [NUM_STATES-1:0][METRIC_W-1:0] pm_out,
        output logic [NUM_STATES-1:0]               dec
    );
        logic [METRIC_W:0] cand0;
        logic [METRIC_W:0] cand1;
        logic [METRIC_W:0] pick;
        for (int n = 0; n < NUM_STATES; n++)
        begin
            cand0 = (METRIC_W+1)'(pm_in[{n[0], 1'b0}])
                  + (METRIC_W+1)'(branch_metric(rx, {n[1:0], 1'b0}, r3));
            cand1 = (METRIC_W+1)'(pm_in[{n[0], 1'b1}])
                  + (METRIC_W+1)'(branch_metric(rx, {n[1:0], 1'b1}, r3));
            dec[n] = (cand1 < cand0);   // ties keep the even predecessor
            pick   = dec[n] ? cand1 : cand0;
            pm_out[n] = pick[METRIC_W] ? {METRIC_W{1'b1}} : pick[METRIC_W-1:0];
        end
    endfunction

    assign rate3 = (i_code_rate == CODE_RATE_3);
    assign rx_a  = rate3 ? i_word.r3.sym0 : {1'b0, i_word.r2.sym0};
    assign rx_b  = rate3 ? i_word.r3.sym1 : {1'b0, i_word.r2.sym1};

    always_comb
    begin
        for (int s = 0; s < NUM_STATES; s++)
            pm_init[s] = (s == 0) ? '0 : {METRIC_W{1'b1}};
        pm_src = i_first ? pm_init : pm;
        acs_step(pm_src, rx_a, rate3, pm_mid, dec_a);
        acs_step(pm_mid, rx_b, rate3, pm_new, dec_b);
    end

    assign cur_idx   = i_first ? 6'd0 : wr_idx;
    assign last_word = (cur_idx == 6'(STEPS_DEC - 1));

    always_ff @(posedge clk) // metrics and survivor memory
    begin
        if (i_word_valid)
        begin
            pm            <= pm_new;
            surv[cur_idx] <= {dec_b, dec_a};
            wr_idx        <= cur_idx + 6'd1;
        end
    end

    always_comb
    begin
        best = 2'd0;
        for (int s = 1; s < NUM_STATES; s++)
            if (pm[s] < pm[best])
                best = s[1:0];
    end

    // one word per cycle: two decisions back to the state before it
    assign surv_rd   = surv[tb_idx];
    assign d_b       = surv_rd[{1'b1, tb_state}];
    assign mid_state = {tb_state[0], d_b};
    assign d_a       = surv_rd[{1'b0, mid_state}];
    assign tb_shift  = {tb_state[0], tb_state[1], tb_bits[MSG_BITS-1:2]};

    always_ff @(posedge clk)
    begin
        if (trace_pend)
        begin
            tb_state <= best;
            tb_idx   <= 6'(STEPS_DEC - 1);
        end
        else if (tracing)
        begin
            tb_state <= {d_b, d_a};
            tb_idx   <= tb_idx - 6'd1;
            tb_bits  <= tb_shift;   // older bits enter at the top
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            collecting <= 1'b0;
            trace_pend <= 1'b0;
            tracing    <= 1'b0;
            o_done     <= 1'b0;
            o_frame    <= '0;
        end
        else
        begin
            trace_pend <= 1'b0;
            o_done     <= 1'b0;
            if (i_word_valid)
            begin
                collecting <= !last_word;
                trace_pend <= last_word;
            end
            if (trace_pend)
                tracing <= 1'b1;
            else if (tracing && tb_idx == 6'd0)
            begin
                tracing <= 1'b0;
                o_done  <= 1'b1;
                o_frame <= tb_shift;   // held until the next frame
            end
        end
    end

    assign o_busy = collecting | trace_pend | tracing;

endmodule
